// ==== logic/fetch_macros.svh ====
`ifndef FETCH_MACROS_SVH
`define FETCH_MACROS_SVH

////////////////////////////////////////////////////////////
// icache geometry
////////////////////////////////////////////////////////////

`define ICACHE_LINES      32            // direct mapped, one 64-bit block per line
`define ICACHE_INDEX_BITS 5             // log2 of ICACHE_LINES

////////////////////////////////////////////////////////////
// fetch control
////////////////////////////////////////////////////////////

`define RESET_PC          32'h0000_0000 // first fetch address out of reset

// cycles spent in WAIT_DATA before the load is sent again
`define RETRY_LIMIT       64

`endif

// ==== logic/fetch_pkg.sv ====
`include "fetch_macros.svh"

package fetch_pkg;

    ////////////////////////////////////////////////////////////
    // widths with a meaning
    ////////////////////////////////////////////////////////////

    typedef logic [31:0] addr_t;        // byte address
    typedef logic [31:0] inst_t;        // one instruction word
    typedef logic [63:0] block_t;       // memory block == cache line
    typedef logic [3:0]  mem_tag_t;     // transaction tag, 0 = not accepted

    // index from addr[7:3], tag from addr[31:8]
    typedef logic [`ICACHE_INDEX_BITS-1:0]      cache_index_t;
    typedef logic [32-`ICACHE_INDEX_BITS-3-1:0] cache_tag_t;

    // memory bus command, same encoding as the core's memory port
    typedef enum logic [1:0] {
        BUS_NONE  = 2'h0,
        BUS_LOAD  = 2'h1,
        BUS_STORE = 2'h2               // never issued by fetch
    } bus_command_e;

    typedef enum logic [1:0] {
        MISS_IDLE      = 2'h0,         // watching for a miss
        MISS_REQUEST   = 2'h1,         // load on the bus until accepted
        MISS_WAIT_DATA = 2'h2          // waiting for the matching reply tag
    } miss_state_e;

    ////////////////////////////////////////////////////////////
    // bundles
    ////////////////////////////////////////////////////////////

    typedef struct packed {
        logic  valid;                  // pc/inst usable this cycle
        addr_t pc;
        inst_t inst;
    } fetch_packet_t;                  // 65 bits

    typedef struct packed {
        logic         valid;           // one-cycle write strobe
        cache_index_t index;
        cache_tag_t   tag;
        block_t       data;
    } fill_t;                          // 94 bits

endpackage

// ==== logic/pc_gen.sv ====
`timescale 1ns/1ps
`include "fetch_macros.svh"

module pc_gen (
    input  logic             clock,
    input  logic             reset,
    input  logic             dispatch_stall,  // back end full, hold
    input  logic             hit,             // current pc delivered
    input  logic             redirect_valid,  // one-cycle strobe
    input  fetch_pkg::addr_t redirect_pc,
    output fetch_pkg::addr_t fetch_pc
);

    fetch_pkg::addr_t pc_next;
    fetch_pkg::addr_t pc_plus4;

    assign pc_plus4 = fetch_pc + 32'd4;       // next sequential word

    ////////////////////////////////////////////////////////////
    // next pc select
    ////////////////////////////////////////////////////////////

    always_comb begin
        pc_next = fetch_pc;                   // hold on stall or miss
        if (redirect_valid) begin
            // redirect wins over stall, force word alignment
            pc_next = {redirect_pc[31:2], 2'b00};
        end else if (hit && !dispatch_stall) begin
            pc_next = pc_plus4;               // instruction went out
        end
    end

    ////////////////////////////////////////////////////////////
    // pc register
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            fetch_pc <= `RESET_PC;
        end else begin
            fetch_pc <= pc_next;
        end
    end

endmodule

// ==== logic/icache_arrays.sv ====
`timescale 1ns/1ps
`include "fetch_macros.svh"

module icache_arrays (
    input  logic              clock,
    input  logic              reset,
    input  fetch_pkg::addr_t  fetch_pc,
    input  fetch_pkg::fill_t  fill,      // write port from the miss fsm
    output logic              hit,
    output fetch_pkg::inst_t  hit_inst
);

    // line storage
    logic [`ICACHE_LINES-1:0] line_valid;
    fetch_pkg::cache_tag_t    line_tag  [`ICACHE_LINES];
    fetch_pkg::block_t        line_data [`ICACHE_LINES];

    fetch_pkg::cache_index_t  pc_index;
    fetch_pkg::cache_tag_t    pc_tag;
    fetch_pkg::block_t        rd_block;

    ////////////////////////////////////////////////////////////
    // lookup
    ////////////////////////////////////////////////////////////

    assign pc_index = fetch_pc[`ICACHE_INDEX_BITS+2:3];   // addr[7:3]
    assign pc_tag   = fetch_pc[31:`ICACHE_INDEX_BITS+3];  // addr[31:8]
    assign rd_block = line_data[pc_index];

    assign hit = line_valid[pc_index] && (line_tag[pc_index] == pc_tag);

    // pc[2] picks the word within the doubleword
    assign hit_inst = fetch_pc[2] ? rd_block[63:32] : rd_block[31:0];

    ////////////////////////////////////////////////////////////
    // fill
    ////////////////////////////////////////////////////////////

    // valid bits cleared on reset
    always_ff @(posedge clock) begin
        if (reset) begin
            line_valid <= '0;                 // every line invalid
        end else if (fill.valid) begin
            line_valid[fill.index] <= 1'b1;
        end
    end

    // tag and data written together with the valid bit
    always_ff @(posedge clock) begin
        if (fill.valid) begin
            line_tag[fill.index]  <= fill.tag;
            line_data[fill.index] <= fill.data;
        end
    end

endmodule

// ==== logic/miss_fsm.sv ====
`timescale 1ns/1ps

module miss_fsm (
    input  logic                    clock,
    input  logic                    reset,
    input  logic                    hit,             // lookup for fetch_pc
    input  logic                    timer_expired,   // reply took too long
    input  fetch_pkg::addr_t        fetch_pc,
    input  fetch_pkg::mem_tag_t     mem2proc_response,
    input  fetch_pkg::mem_tag_t     mem2proc_tag,
    input  fetch_pkg::block_t       mem2proc_data,
    output fetch_pkg::bus_command_e proc2mem_command,
    output fetch_pkg::addr_t        proc2mem_addr,
    output fetch_pkg::fill_t        fill,
    output logic                    timer_run
);

    fetch_pkg::miss_state_e state;
    fetch_pkg::miss_state_e state_next;
    fetch_pkg::addr_t       miss_addr;       // block address being filled
    fetch_pkg::mem_tag_t    miss_tag;        // tag given when our load was taken
    logic                   accepted;
    logic                   reply_match;

    // memory took the load this cycle
    assign accepted = (state == fetch_pkg::MISS_REQUEST) && (mem2proc_response != '0);

    // reply for our load, stale tags from a retried load fall through
    assign reply_match = (state == fetch_pkg::MISS_WAIT_DATA)
                         && (mem2proc_tag != '0)
                         && (mem2proc_tag == miss_tag);

    ////////////////////////////////////////////////////////////
    // state machine
    ////////////////////////////////////////////////////////////

    always_comb begin
        state_next = state;
        case (state)
            fetch_pkg::MISS_IDLE: begin
                if (!hit) state_next = fetch_pkg::MISS_REQUEST;
            end
            fetch_pkg::MISS_REQUEST: begin
                if (accepted) state_next = fetch_pkg::MISS_WAIT_DATA;
            end
            fetch_pkg::MISS_WAIT_DATA: begin
                if (reply_match) begin
                    state_next = fetch_pkg::MISS_IDLE;     // data beats the timer
                end else if (timer_expired) begin
                    state_next = fetch_pkg::MISS_REQUEST;  // send it again
                end
            end
            default: state_next = fetch_pkg::MISS_IDLE;
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= fetch_pkg::MISS_IDLE;
        end else begin
            state <= state_next;
        end
    end

    // miss address held until the fill is done, redirects wait for it
    always_ff @(posedge clock) begin
        if (state == fetch_pkg::MISS_IDLE && !hit) begin
            miss_addr <= {fetch_pc[31:3], 3'b000};
        end
        if (accepted) begin
            miss_tag <= mem2proc_response;   // retry overwrites the old tag
        end
    end

    ////////////////////////////////////////////////////////////
    // outputs
    ////////////////////////////////////////////////////////////

    assign proc2mem_command = (state == fetch_pkg::MISS_REQUEST) ? fetch_pkg::BUS_LOAD
                                                                  : fetch_pkg::BUS_NONE;
    assign proc2mem_addr    = (state == fetch_pkg::MISS_REQUEST) ? miss_addr : '0;
    assign timer_run        = (state == fetch_pkg::MISS_WAIT_DATA);

    always_comb begin
        fill.valid = reply_match;            // single-cycle write
        fill.index = fetch_pkg::cache_index_t'(miss_addr >> 3);
        fill.tag   = fetch_pkg::cache_tag_t'(miss_addr >> ($bits(fetch_pkg::cache_index_t) + 3));
        fill.data  = mem2proc_data;
    end

endmodule

// ==== logic/retry_timer.sv ====
`timescale 1ns/1ps
`include "fetch_macros.svh"

module retry_timer (
    input  logic clock,
    input  logic reset,
    input  logic timer_run,       // high while a reply is outstanding
    output logic timer_expired
);

    // wide enough to hold RETRY_LIMIT itself
    localparam int unsigned COUNT_BITS = $clog2(`RETRY_LIMIT + 1);

    logic [COUNT_BITS-1:0] wait_count;

    ////////////////////////////////////////////////////////////
    // wait counter
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset || !timer_run) begin
            wait_count <= '0;                      // fresh count per wait
        end else if (!timer_expired) begin
            wait_count <= wait_count + 1'b1;       // saturates at the limit
        end
    end

    assign timer_expired = (wait_count == COUNT_BITS'(`RETRY_LIMIT));

endmodule

// ==== logic/fetch_front.sv ====
`timescale 1ns/1ps

module fetch_front (
    input  logic                     clock,
    input  logic                     reset,
    input  logic                     dispatch_stall,     // level from dispatch
    input  logic                     redirect_valid,     // strobe from the back end
    input  fetch_pkg::addr_t         redirect_pc,
    input  fetch_pkg::mem_tag_t      mem2proc_response,  // tag for the current request
    input  fetch_pkg::mem_tag_t      mem2proc_tag,       // tag of the current reply
    input  fetch_pkg::block_t        mem2proc_data,
    output fetch_pkg::bus_command_e  proc2mem_command,
    output fetch_pkg::addr_t         proc2mem_addr,
    output fetch_pkg::fetch_packet_t fetch_packet
);

    fetch_pkg::addr_t fetch_pc;
    logic             hit;
    fetch_pkg::inst_t hit_inst;
    fetch_pkg::fill_t fill;
    logic             timer_run;
    logic             timer_expired;

    ////////////////////////////////////////////////////////////
    // pc and icache
    ////////////////////////////////////////////////////////////

    pc_gen pc_gen_inst (
        .clock          (clock),
        .reset          (reset),
        .dispatch_stall (dispatch_stall),
        .hit            (hit),            // advance only on delivery
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .fetch_pc       (fetch_pc)
    );

    icache_arrays icache_arrays_inst (
        .clock    (clock),
        .reset    (reset),
        .fetch_pc (fetch_pc),
        .fill     (fill),
        .hit      (hit),
        .hit_inst (hit_inst)
    );

    ////////////////////////////////////////////////////////////
    // miss handling
    ////////////////////////////////////////////////////////////

    miss_fsm miss_fsm_inst (
        .clock             (clock),
        .reset             (reset),
        .hit               (hit),
        .timer_expired     (timer_expired),
        .fetch_pc          (fetch_pc),
        .mem2proc_response (mem2proc_response),
        .mem2proc_tag      (mem2proc_tag),
        .mem2proc_data     (mem2proc_data),
        .proc2mem_command  (proc2mem_command),  // sole driver of the bus
        .proc2mem_addr     (proc2mem_addr),
        .fill              (fill),
        .timer_run         (timer_run)
    );

    retry_timer retry_timer_inst (
        .clock         (clock),
        .reset         (reset),
        .timer_run     (timer_run),
        .timer_expired (timer_expired)
    );

    // packet to decode, valid same cycle as the hit
    assign fetch_packet = '{valid: hit, pc: fetch_pc, inst: hit_inst};

endmodule

// ==== verif/fetch_front_tb.sv ====
`timescale 1ns/1ps
`include "fetch_macros.svh"

module fetch_front_tb;

    ////////////////////////////////////////////////////////////
    // cycle budgets
    ////////////////////////////////////////////////////////////

    localparam int MISS_CYCLES     = 20;                          // fill queued behind another
    localparam int RETRY_CYCLES    = `RETRY_LIMIT + MISS_CYCLES;  // one lost reply
    localparam int PACKET_TIMEOUT  = 2 * RETRY_CYCLES;
    localparam int QUIET_TIMEOUT   = 2 * MISS_CYCLES;
    localparam int TEST_CYCLES     = 12 * MISS_CYCLES             // sequential
                                   + 8 + 3 * MISS_CYCLES          // stall
                                   + 2 + 4 * MISS_CYCLES          // redirect
                                   + 8 + QUIET_TIMEOUT            // cached redirect
                                   + 2 + RETRY_CYCLES + 2 * MISS_CYCLES;
    localparam int WATCHDOG_CYCLES = 2 * (10 + TEST_CYCLES);

    logic                     clock;
    logic                     reset;
    logic                     dispatch_stall;
    logic                     redirect_valid;
    fetch_pkg::addr_t         redirect_pc;
    fetch_pkg::mem_tag_t      mem2proc_response;
    fetch_pkg::mem_tag_t      mem2proc_tag;
    fetch_pkg::block_t        mem2proc_data;
    fetch_pkg::bus_command_e  proc2mem_command;
    fetch_pkg::addr_t         proc2mem_addr;
    fetch_pkg::fetch_packet_t fetch_packet;

    // memory model state
    fetch_pkg::mem_tag_t next_tag;         // cycles 1..15
    fetch_pkg::mem_tag_t reply_tag_q[$];
    fetch_pkg::block_t   reply_data_q[$];
    int unsigned         reply_due_q[$];
    int unsigned         mem_cycle;
    int                  load_count;
    logic                drop_armed;       // lose the next reply for drop_addr
    fetch_pkg::addr_t    drop_addr;
    int                  drop_addr_loads;
    logic                stale_held;       // lost reply comes back after the retry
    fetch_pkg::mem_tag_t stale_tag;
    logic                stale_sent;

    int test_count;
    int check_count;
    int error_count;

    fetch_front fetch_front_inst (
        .clock             (clock),
        .reset             (reset),
        .dispatch_stall    (dispatch_stall),
        .redirect_valid    (redirect_valid),
        .redirect_pc       (redirect_pc),
        .mem2proc_response (mem2proc_response),
        .mem2proc_tag      (mem2proc_tag),
        .mem2proc_data     (mem2proc_data),
        .proc2mem_command  (proc2mem_command),
        .proc2mem_addr     (proc2mem_addr),
        .fetch_packet      (fetch_packet)
    );

    always #10 clock = ~clock;             // 20 ns period

    ////////////////////////////////////////////////////////////
    // content rule and check helpers
    ////////////////////////////////////////////////////////////

    function automatic fetch_pkg::inst_t word_at(input fetch_pkg::addr_t addr);
        return addr ^ 32'hC0DE_0000;       // every word names its own address
    endfunction

    function automatic fetch_pkg::block_t block_at(input fetch_pkg::addr_t addr);
        fetch_pkg::addr_t base;
        base = {addr[31:3], 3'b000};
        return {word_at(base + 32'd4), word_at(base)};  // high word at +4
    endfunction

    task automatic compare_word(input string what, input logic [31:0] actual,
                                input logic [31:0] expected);
        check_count++;
        assert (actual === expected) else begin
            $display("** Error at %0t: %s is %h, expected %h", $time, what, actual, expected);
            error_count++;
        end
    endtask

    task automatic note_failure(input string what);
        $display("%s", what);
        error_count++;
    endtask

    task automatic close_test(input string name, input int errors_before);
        test_count++;
        $display("test %s done, %0d errors", name, error_count - errors_before);
    endtask

    task automatic check_packet(input fetch_pkg::fetch_packet_t pkt,
                                input fetch_pkg::addr_t expected_pc);
        compare_word("packet pc", pkt.pc, expected_pc);
        compare_word("packet inst", pkt.inst, word_at(expected_pc));
    endtask

    // looks at the current falling edge first and then steps
    task automatic wait_packet(output fetch_pkg::fetch_packet_t pkt, output logic found);
        int waited;
        waited = 0;
        while (!fetch_packet.valid && waited < PACKET_TIMEOUT) begin
            @(negedge clock);
            waited++;
        end
        found = fetch_packet.valid;
        pkt   = fetch_packet;
    endtask

    // counts packets in order from start_pc and returns on an unconsumed edge
    task automatic fetch_run(input fetch_pkg::addr_t start_pc, input int count,
                             input logic bus_quiet);
        fetch_pkg::fetch_packet_t pkt;
        fetch_pkg::addr_t         pc;
        logic                     found;
        pc = start_pc;
        for (int i = 0; i < count; i++) begin
            wait_packet(pkt, found);
            if (!found) begin
                note_failure($sformatf("no valid packet for pc %h within %0d cycles",
                                       pc, PACKET_TIMEOUT));
                return;
            end
            check_packet(pkt, pc);
            if (bus_quiet) begin
                compare_word("proc2mem_command", 32'(proc2mem_command),
                             32'(fetch_pkg::BUS_NONE));
            end
            pc = pc + 32'd4;
            @(negedge clock);
        end
    endtask

    task automatic strobe_redirect(input fetch_pkg::addr_t target);
        redirect_valid = 1'b1;
        redirect_pc    = target;
        @(negedge clock);                  // pc loaded at the edge in between
        redirect_valid = 1'b0;
    endtask

    ////////////////////////////////////////////////////////////
    // tagged memory model
    ////////////////////////////////////////////////////////////

    always @(negedge clock) begin : memory_model
        int unsigned delay;
        if (reset) begin
            mem2proc_response = '0;
            mem2proc_tag      = '0;
            mem2proc_data     = '0;
        end else begin
            mem_cycle     = mem_cycle + 1;
            mem2proc_tag  = '0;            // idle reply bus
            mem2proc_data = '0;
            if (reply_tag_q.size() > 0 && reply_due_q[0] <= mem_cycle) begin
                mem2proc_tag  = reply_tag_q.pop_front();
                mem2proc_data = reply_data_q.pop_front();
                void'(reply_due_q.pop_front());
            end
            mem2proc_response = '0;
            if (proc2mem_command == fetch_pkg::BUS_LOAD) begin
                mem2proc_response = next_tag;  // accept every load at once
                load_count++;
                if (proc2mem_addr == drop_addr) drop_addr_loads++;
                if (drop_armed && proc2mem_addr == drop_addr) begin
                    drop_armed = 1'b0;
                    stale_held = 1'b1;
                    stale_tag  = next_tag;
                end else begin
                    delay = 1 + ($urandom % 8);
                    if (stale_held) begin
                        // old tag shows up first with the real data after it
                        reply_tag_q.push_back(stale_tag);
                        reply_data_q.push_back(64'hDEAD_BEEF_0BAD_F00D);
                        reply_due_q.push_back(mem_cycle + 1);
                        delay      = delay + 1;
                        stale_held = 1'b0;
                        stale_sent = 1'b1;
                    end
                    reply_tag_q.push_back(next_tag);
                    reply_data_q.push_back(block_at(proc2mem_addr));
                    reply_due_q.push_back(mem_cycle + delay);
                end
                next_tag = (next_tag == 4'd15) ? 4'd1 : next_tag + 4'd1;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // directed tests
    ////////////////////////////////////////////////////////////

    task automatic sequential_fetch();
        int errors_before;
        errors_before = error_count;
        compare_word("valid after reset", 32'(fetch_packet.valid), 32'd0);
        compare_word("command after reset", 32'(proc2mem_command), 32'(fetch_pkg::BUS_NONE));
        compare_word("pc after reset", fetch_packet.pc, `RESET_PC);
        fetch_run(`RESET_PC, 12, 1'b0);    // six line misses
        close_test("sequential_fetch", errors_before);
    endtask

    task automatic stall_hold(input fetch_pkg::addr_t start_pc);
        fetch_pkg::fetch_packet_t held;
        logic                     found;
        int                       errors_before;
        errors_before = error_count;
        wait_packet(held, found);
        if (!found) begin
            note_failure("no valid packet to stall on");
            close_test("stall_hold", errors_before);
            return;
        end
        check_packet(held, start_pc);
        dispatch_stall = 1'b1;
        repeat (5) begin
            @(negedge clock);
            compare_word("stalled valid", 32'(fetch_packet.valid), 32'd1);
            compare_word("stalled pc", fetch_packet.pc, start_pc);
            compare_word("stalled inst", fetch_packet.inst, word_at(start_pc));
        end
        dispatch_stall = 1'b0;
        @(negedge clock);                  // held packet goes out here
        fetch_run(start_pc + 32'd4, 2, 1'b0);
        close_test("stall_hold", errors_before);
    endtask

    task automatic redirect_fetch();
        fetch_pkg::addr_t target;
        int               errors_before;
        errors_before = error_count;
        target = ($urandom & 32'h0FFF_FF00) | 32'h0000_0084;  // high word of index 16
        strobe_redirect(target);
        fetch_run(target, 4, 1'b0);
        close_test("redirect_fetch", errors_before);
    endtask

    task automatic cached_redirect();
        int quiet;
        int waited;
        int loads_before;
        int errors_before;
        errors_before  = error_count;
        dispatch_stall = 1'b1;             // park on a line from the first test
        strobe_redirect(`RESET_PC + 32'd8);
        quiet  = 0;
        waited = 0;
        while (quiet < 3 && waited < QUIET_TIMEOUT) begin
            @(negedge clock);
            waited++;
            if (proc2mem_command == fetch_pkg::BUS_NONE && reply_tag_q.size() == 0
                && !stale_held) begin
                quiet++;
            end else begin
                quiet = 0;
            end
        end
        if (quiet < 3) note_failure("memory traffic did not settle before the cached fetch");
        loads_before   = load_count;
        dispatch_stall = 1'b0;
        fetch_run(`RESET_PC + 32'd8, 3, 1'b1);
        compare_word("loads during cached fetch", 32'(load_count), 32'(loads_before));
        close_test("cached_redirect", errors_before);
    endtask

    task automatic lost_reply_retry();
        fetch_pkg::addr_t target;
        int               errors_before;
        errors_before   = error_count;
        target          = ($urandom & 32'h0FFF_FF00) | 32'h0000_00C4;  // index 24
        drop_addr       = {target[31:3], 3'b000};
        drop_addr_loads = 0;
        drop_armed      = 1'b1;
        strobe_redirect(target);
        fetch_run(target, 2, 1'b0);
        compare_word("loads of the dropped block", 32'(drop_addr_loads), 32'd2);
        compare_word("stale reply sent", 32'(stale_sent), 32'd1);
        close_test("lost_reply_retry", errors_before);
    endtask

    ////////////////////////////////////////////////////////////
    // main sequence and watchdog
    ////////////////////////////////////////////////////////////

    initial begin
        void'($urandom(32'h526c));
        clock             = 1'b0;
        reset             = 1'b1;
        dispatch_stall    = 1'b0;
        redirect_valid    = 1'b0;
        redirect_pc       = '0;
        mem2proc_response = '0;
        mem2proc_tag      = '0;
        mem2proc_data     = '0;
        next_tag          = 4'd1;
        mem_cycle         = 0;
        load_count        = 0;
        drop_armed        = 1'b0;
        drop_addr         = '0;
        drop_addr_loads   = 0;
        stale_held        = 1'b0;
        stale_tag         = '0;
        stale_sent        = 1'b0;
        test_count        = 0;
        check_count       = 0;
        error_count       = 0;
        repeat (10) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;
        sequential_fetch();
        stall_hold(`RESET_PC + 32'd48);    // next pc after twelve packets
        redirect_fetch();
        cached_redirect();
        lost_reply_retry();
        $display("tests %0d, checks %0d, errors %0d", test_count, check_count, error_count);
        if (error_count == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge clock);
        $display("watchdog expired after %0d cycles, tests did not finish", WATCHDOG_CYCLES);
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

// ==== list.f ====
+incdir+logic
logic/fetch_pkg.sv
logic/pc_gen.sv
logic/icache_arrays.sv
logic/miss_fsm.sv
logic/retry_timer.sv
logic/fetch_front.sv
verif/fetch_front_tb.sv

// ==== run.sh ====
#!/bin/sh
# compile and run the fetch_front testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --timescale 1ns/1ps \
    --top-module fetch_front_tb \
    -f list.f \
    -o fetch_front_sim

./obj_dir/fetch_front_sim > sim.log 2>&1
cat sim.log

if grep -q "RESULT: FAIL" sim.log; then
    echo "simulation reported failure, see sim.log"
    exit 1
fi

echo "simulation finished without failure"
